/* source/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH
`default_nettype none

`define WORD_WIDTH 32
`define REG_COUNT 16
`define IMM_WIDTH 19

`define OP_ST 5'd2
`define OP_ADD 5'd3
`define OP_SUB 5'd4
`define OP_AND 5'd5
`define OP_OR 5'd6
`define OP_SHL 5'd9
`define OP_ADDI 5'd12
`define OP_HALT 5'd27

`define ALU_ADD 3'd0
`define ALU_SUB 3'd1
`define ALU_AND 3'd2
`define ALU_OR 3'd3
`define ALU_SHL 3'd4
`define ALU_INC 3'd5

`define BUS_REG 3'd0
`define BUS_PC 3'd1
`define BUS_MDR 3'd2
`define BUS_ZLOW 3'd3
`define BUS_IMM 3'd4

// which IR field addresses the register bank for reading
`define SRC_RA 2'd0
`define SRC_RB 2'd1
`define SRC_RC 2'd2

`default_nettype wire
`endif

/* source/cpuPkg.sv */
`include "cpu_params.svh"
`default_nettype none

package cpuPkg;

	typedef logic [`WORD_WIDTH-1:0] word_t; // data, address and instruction
	typedef logic [$clog2(`REG_COUNT)-1:0] regIndex_t;
	typedef logic [4:0] opcode_t;
	typedef logic [2:0] aluOp_t;
	typedef logic [2:0] busSelect_t; // one driver of the internal bus

endpackage

`default_nettype wire

/* source/aluUnit.sv */
`timescale 1ns/100ps
`include "cpu_params.svh"
`default_nettype none

module aluUnit (
	input  cpuPkg::word_t  yValue,
	input  cpuPkg::word_t  busValue,
	input  cpuPkg::aluOp_t aluOp,
	output cpuPkg::word_t  result
);
	import cpuPkg::*;

	always_comb
	begin
		case (aluOp)
			`ALU_ADD: result = yValue + busValue;
			`ALU_SUB: result = yValue - busValue;
			`ALU_AND: result = yValue & busValue;
			`ALU_OR: result = yValue | busValue;
			`ALU_SHL: result = yValue << busValue[4:0]; // only low 5 bits count
			`ALU_INC: result = busValue + word_t'(4); // next pc, y not used
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* source/controlSequencer.sv */
`timescale 1ns/100ps
`include "cpu_params.svh"
`default_nettype none

module controlSequencer (
	input  logic               clock,
	input  logic               rst,
	input  cpuPkg::opcode_t    opcode,
	output cpuPkg::busSelect_t busSelect,
	output logic [1:0]         regSource,
	output logic               regIn,
	output logic               yIn,
	output logic               zIn,
	output cpuPkg::aluOp_t     aluOp,
	output logic               pcIn,
	output logic               irIn,
	output logic               marIn,
	output logic               mdrIn,
	output logic               mdrFromBus,
	output logic               memRead,
	output logic               memWrite,
	output logic               halted
);
	import cpuPkg::*;

	typedef enum logic [3:0] {
		fetch0, fetch1, fetch2, exec3, exec4, exec5, exec6, exec7, haltState
	} state_t;

	state_t state;
	state_t nextState;
	logic isRegOp;
	logic isStore;
	logic isHalt;
	aluOp_t regAluOp;

	always_comb
	begin
		isRegOp = 1'b0;
		isStore = 1'b0;
		isHalt = 1'b0;
		regAluOp = `ALU_ADD;
		case (opcode)
			`OP_ADD: isRegOp = 1'b1;
			`OP_SUB:
			begin
				isRegOp = 1'b1;
				regAluOp = `ALU_SUB;
			end
			`OP_AND:
			begin
				isRegOp = 1'b1;
				regAluOp = `ALU_AND;
			end
			`OP_OR:
			begin
				isRegOp = 1'b1;
				regAluOp = `ALU_OR;
			end
			`OP_SHL:
			begin
				isRegOp = 1'b1;
				regAluOp = `ALU_SHL;
			end
			`OP_ADDI: ; // same path as a register op, immediate at T4
			`OP_ST: isStore = 1'b1;
			`OP_HALT: isHalt = 1'b1;
			default: isHalt = 1'b1; // unknown opcodes stop the core too
		endcase
	end

	always_comb
	begin
		case (state)
			fetch0: nextState = fetch1;
			fetch1: nextState = fetch2;
			fetch2: nextState = exec3;
			exec3: nextState = isHalt ? haltState : exec4;
			exec4: nextState = exec5;
			exec5: nextState = isStore ? exec6 : fetch0;
			exec6: nextState = exec7;
			exec7: nextState = fetch0;
			default: nextState = haltState; // left only by reset
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (rst)
			state <= fetch0;
		else
			state <= nextState;
	end

	always_comb
	begin
		busSelect = `BUS_REG;
		regSource = `SRC_RA;
		regIn = 1'b0;
		yIn = 1'b0;
		zIn = 1'b0;
		aluOp = `ALU_ADD;
		pcIn = 1'b0;
		irIn = 1'b0;
		marIn = 1'b0;
		mdrIn = 1'b0;
		mdrFromBus = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		case (state)
			fetch0:
			begin
				busSelect = `BUS_PC;
				marIn = 1'b1;
				aluOp = `ALU_INC;
				zIn = 1'b1;
			end
			fetch1:
			begin
				busSelect = `BUS_ZLOW;
				pcIn = 1'b1;
				memRead = 1'b1;
				mdrIn = 1'b1; // mdr takes memDataIn
			end
			fetch2:
			begin
				busSelect = `BUS_MDR;
				irIn = 1'b1;
			end
			exec3:
			begin
				regSource = `SRC_RB;
				yIn = !isHalt;
			end
			exec4:
			begin
				zIn = 1'b1;
				if (isRegOp)
				begin
					regSource = `SRC_RC;
					aluOp = regAluOp;
				end
				else
					busSelect = `BUS_IMM; // addi and st: rb + imm
			end
			exec5:
			begin
				busSelect = `BUS_ZLOW;
				marIn = isStore; // store address
				regIn = !isStore;
			end
			exec6:
			begin
				mdrIn = 1'b1;
				mdrFromBus = 1'b1; // ra is the store data
			end
			exec7: memWrite = 1'b1;
			default: ;
		endcase
	end

	assign halted = (state == haltState);

endmodule

`default_nettype wire

/* source/busDatapath.sv */
`timescale 1ns/100ps
`include "cpu_params.svh"
`default_nettype none

module busDatapath (
	input  logic               clock,
	input  logic               rst,
	input  cpuPkg::busSelect_t busSelect,
	input  logic [1:0]         regSource,
	input  logic               regIn,
	input  logic               yIn,
	input  logic               zIn,
	input  cpuPkg::aluOp_t     aluOp,
	input  cpuPkg::regIndex_t  ra,
	input  cpuPkg::regIndex_t  rb,
	input  cpuPkg::regIndex_t  rc,
	input  cpuPkg::word_t      pcValue,
	input  cpuPkg::word_t      mdrValue,
	input  cpuPkg::word_t      immValue,
	output cpuPkg::word_t      bus
);
	import cpuPkg::*;

	word_t regBank [`REG_COUNT];
	word_t yReg;
	word_t zReg;
	word_t aluResult;
	regIndex_t readIndex;

	always_comb
	begin
		case (regSource)
			`SRC_RB: readIndex = rb;
			`SRC_RC: readIndex = rc;
			default: readIndex = ra;
		endcase
	end

	always_comb
	begin
		case (busSelect)
			`BUS_REG: bus = regBank[readIndex];
			`BUS_PC: bus = pcValue;
			`BUS_MDR: bus = mdrValue;
			`BUS_ZLOW: bus = zReg;
			`BUS_IMM: bus = immValue;
			default: bus = '0;
		endcase
	end

	// general registers start at zero, r0 included
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
				regBank[i] <= '0;
		end
		else if (regIn)
			regBank[ra] <= bus; // results always land in ra
	end

	always_ff @(posedge clock)
	begin
		if (yIn)
			yReg <= bus;
		if (zIn)
			zReg <= aluResult;
	end

	aluUnit aluInst (
		.yValue   (yReg),
		.busValue (bus),
		.aluOp    (aluOp),
		.result   (aluResult)
	);

endmodule

`default_nettype wire

/* source/memoryInterface.sv */
`timescale 1ns/100ps
`default_nettype none

module memoryInterface (
	input  logic          clock,
	input  logic          rst,
	input  cpuPkg::word_t bus,
	input  logic          marIn,
	input  logic          mdrIn,
	input  logic          mdrFromBus,
	input  cpuPkg::word_t memDataIn,
	output cpuPkg::word_t memAddress,
	output cpuPkg::word_t memDataOut,
	output cpuPkg::word_t mdrValue
);
	import cpuPkg::*;

	word_t marReg;
	word_t mdrReg;

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			marReg <= '0;
			mdrReg <= '0;
		end
		else
		begin
			if (marIn)
				marReg <= bus;
			if (mdrIn)
				mdrReg <= mdrFromBus ? bus : memDataIn; // memory answers same cycle
		end
	end

	assign memAddress = marReg;
	assign memDataOut = mdrReg;
	assign mdrValue = mdrReg;

endmodule

`default_nettype wire

/* source/programUnit.sv */
`timescale 1ns/100ps
`include "cpu_params.svh"
`default_nettype none

module programUnit (
	input  logic              clock,
	input  logic              rst,
	input  cpuPkg::word_t     bus,
	input  logic              pcIn,
	input  logic              irIn,
	output cpuPkg::word_t     pcValue,
	output cpuPkg::word_t     immValue,
	output cpuPkg::opcode_t   opcode,
	output cpuPkg::regIndex_t ra,
	output cpuPkg::regIndex_t rb,
	output cpuPkg::regIndex_t rc
);
	import cpuPkg::*;

	word_t pcReg;
	word_t irReg;

	always_ff @(posedge clock)
	begin
		if (rst)
			pcReg <= '0; // fetch starts at address 0
		else if (pcIn)
			pcReg <= bus;
	end

	always_ff @(posedge clock)
	begin
		if (irIn)
			irReg <= bus;
	end

	assign pcValue = pcReg;
	assign opcode = irReg[31:27];
	assign ra = irReg[26:23];
	assign rb = irReg[22:19];
	assign rc = irReg[18:15]; // overlaps the immediate
	assign immValue = {{(`WORD_WIDTH - `IMM_WIDTH){irReg[`IMM_WIDTH-1]}},
		irReg[`IMM_WIDTH-1:0]};

endmodule

`default_nettype wire

/* source/cpuCore.sv */
`timescale 1ns/100ps
`default_nettype none

module cpuCore (
	input  logic          clock,
	input  logic          rst,
	input  cpuPkg::word_t memDataIn,
	output cpuPkg::word_t memAddress,
	output cpuPkg::word_t memDataOut,
	output logic          memRead,
	output logic          memWrite,
	output logic          halted
);
	import cpuPkg::*;

	busSelect_t busSelect;
	aluOp_t aluOp;
	opcode_t opcode;
	logic [1:0] regSource;
	logic regIn;
	logic yIn;
	logic zIn;
	logic pcIn;
	logic irIn;
	logic marIn;
	logic mdrIn;
	logic mdrFromBus;
	regIndex_t ra;
	regIndex_t rb;
	regIndex_t rc;
	word_t bus; // the single shared bus
	word_t pcValue;
	word_t mdrValue;
	word_t immValue;

	// all connections go by name
	controlSequencer sequencer (.*);

	busDatapath datapath (.*);

	memoryInterface memUnit (.*);

	programUnit progUnit (.*);

endmodule

`default_nettype wire

/* bench/cpuCore_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module cpuCoreProperties (
	input logic clock,
	input logic rst,
	input logic memRead,
	input logic memWrite,
	input logic halted
);

	assert property (@(posedge clock) disable iff (rst) !(memRead && memWrite))
		else $error("memRead and memWrite high together");

	// only reset leaves the halted state
	assert property (@(posedge clock) disable iff (rst) halted |=> halted)
		else $error("halted fell without a reset");

	assert property (@(posedge clock) disable iff (rst) halted |-> !memRead && !memWrite)
		else $error("memory strobe while halted");

	assert property (@(posedge clock) rst |=> !memRead && !memWrite && !halted)
		else $error("strobe or halted high in the cycle after reset");

endmodule

bind cpuCore cpuCoreProperties props (
	.clock    (clock),
	.rst      (rst),
	.memRead  (memRead),
	.memWrite (memWrite),
	.halted   (halted)
);

`default_nettype wire

/* bench/cpuCoreTb.sv */
`timescale 1ns/100ps
`include "cpu_params.svh"
`default_nettype none

module cpuCoreTb;
	import cpuPkg::*;

	localparam int OP_COUNT = 40;
	localparam int HALT_TIMEOUT = 2000;
	localparam int QUIET_CYCLES = 50;

	logic clock;
	logic rst;
	word_t memDataIn;
	word_t memAddress;
	word_t memDataOut;
	logic memRead;
	logic memWrite;
	logic halted;

	word_t mem [256];
	word_t modelRegs [`REG_COUNT];
	word_t storeAddrQ [$];
	word_t storeDataQ [$];
	word_t expectedPc;
	word_t nextPc;
	word_t refAddr;
	word_t refData;
	logic refStore;
	logic refHalt;
	logic haltFetched;
	int storeCount;
	int programStores;

	cpuCore u_dut (
		.clock      (clock),
		.rst        (rst),
		.memDataIn  (memDataIn),
		.memAddress (memAddress),
		.memDataOut (memDataOut),
		.memRead    (memRead),
		.memWrite   (memWrite),
		.halted     (halted)
	);

	assign memDataIn = mem[memAddress[9:2]]; // answers in the same cycle

	initial
	begin
		clock = 1'b0;
		forever
			#4 clock = ~clock;
	end

	task automatic failRun(input string what);
		$display("%s", what);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string testName, input word_t expected, input word_t actual);
		if (actual !== expected)
			failRun($sformatf("ERROR %s expected %h actual %h", testName, expected, actual));
	endtask

	function automatic word_t encode(input opcode_t op, input regIndex_t ra, input regIndex_t rb,
		input logic [18:0] low);
		return {op, ra, rb, low};
	endfunction

	// one instruction against the model register file
	function automatic void executeInstr(input word_t instr, input word_t pc,
		output word_t newPc, output logic isStore, output word_t storeAddr,
		output word_t storeData, output logic isHalt);
		opcode_t op;
		regIndex_t ra;
		regIndex_t rb;
		regIndex_t rc;
		word_t imm;
		op = instr[31:27];
		ra = instr[26:23];
		rb = instr[22:19];
		rc = instr[18:15];
		imm = {{13{instr[18]}}, instr[18:0]};
		newPc = pc + 32'd4;
		isStore = 1'b0;
		isHalt = 1'b0;
		storeAddr = '0;
		storeData = '0;
		case (op)
			`OP_ADD: modelRegs[ra] = modelRegs[rb] + modelRegs[rc];
			`OP_SUB: modelRegs[ra] = modelRegs[rb] - modelRegs[rc];
			`OP_AND: modelRegs[ra] = modelRegs[rb] & modelRegs[rc];
			`OP_OR: modelRegs[ra] = modelRegs[rb] | modelRegs[rc];
			`OP_SHL: modelRegs[ra] = modelRegs[rb] << modelRegs[rc][4:0];
			`OP_ADDI: modelRegs[ra] = modelRegs[rb] + imm;
			`OP_ST:
			begin
				isStore = 1'b1;
				storeAddr = modelRegs[rb] + imm;
				storeData = modelRegs[ra];
			end
			default: isHalt = 1'b1; // halt and unknown codes
		endcase
	endfunction

	task automatic buildProgram();
		int pos;
		int sel;
		word_t r;
		word_t storeImm;
		opcode_t op;
		regIndex_t dest;
		for (int i = 0; i < 256; i++)
			mem[i] = {`OP_HALT, 27'(i * 4)}; // unused words halt, tagged with their address
		pos = 0;
		mem[pos] = encode(`OP_ADDI, 4'd15, 4'd15, 19'd2048); // r15 is the store base
		pos++;
		for (int i = 0; i < 15; i++)
		begin
			r = $urandom();
			mem[pos] = encode(`OP_ADDI, 4'(i), r[22:19], r[18:0]); // random sign
			pos++;
		end
		for (int k = 0; k < OP_COUNT; k++)
		begin
			r = $urandom();
			sel = $urandom_range(4, 0);
			case (sel)
				0: op = `OP_ADD;
				1: op = `OP_SUB;
				2: op = `OP_AND;
				3: op = `OP_OR;
				default: op = `OP_SHL;
			endcase
			dest = r[3:0] % 4'd15; // r15 keeps the base
			mem[pos] = encode(op, dest, r[7:4], {r[11:8], 15'd0});
			pos++;
			storeImm = word_t'(4 * k - 1536); // negative, lands at word 128 + k
			mem[pos] = encode(`OP_ST, dest, 4'd15, storeImm[18:0]);
			pos++;
		end
		mem[pos] = encode(`OP_HALT, 4'd0, 4'd0, 19'd0);
		programStores = OP_COUNT;
	endtask

	task automatic waitForHalt();
		int cycles;
		cycles = 0;
		while (halted !== 1'b1)
		begin
			@(posedge clock);
			cycles++;
			if (cycles > HALT_TIMEOUT)
				failRun("timeout: halted did not rise after the halt instruction");
		end
	endtask

	always @(posedge clock)
	begin
		if (!rst && memWrite)
			mem[memAddress[9:2]] = memDataOut;
	end

	always @(posedge clock)
	begin
		if (!rst)
		begin
			if (halted && !haltFetched)
				failRun("halted rose before the halt instruction was fetched");
			else if (halted && (memRead || memWrite))
				failRun("memory strobe seen after the core halted");
			if (memRead)
			begin
				checkValue("fetch address", expectedPc, memAddress);
				executeInstr(mem[expectedPc[9:2]], expectedPc, nextPc, refStore, refAddr,
					refData, refHalt);
				if (refStore)
				begin
					storeAddrQ.push_back(refAddr);
					storeDataQ.push_back(refData);
				end
				if (refHalt)
					haltFetched = 1'b1;
				expectedPc = nextPc;
			end
			if (memWrite)
			begin
				if (storeAddrQ.size() == 0)
					failRun("memory write without a fetched store instruction");
				else
				begin
					checkValue($sformatf("store %0d address", storeCount),
						storeAddrQ.pop_front(), memAddress);
					checkValue($sformatf("store %0d data", storeCount),
						storeDataQ.pop_front(), memDataOut);
					storeCount++;
				end
			end
		end
	end

	initial
	begin
		rst = 1'b1;
		expectedPc = '0;
		haltFetched = 1'b0;
		storeCount = 0;
		for (int i = 0; i < `REG_COUNT; i++)
			modelRegs[i] = '0;
		void'($urandom(32'h8f35));
		buildProgram();
		for (int c = 0; c < 4; c++)
		begin
			@(posedge clock);
			if (c > 0) // state is unknown before the first edge
				checkValue("strobes in reset", '0, word_t'({memRead, memWrite, halted}));
		end
		rst <= 1'b0;
		@(posedge clock);
		checkValue("strobes after reset", '0, word_t'({memRead, memWrite, halted}));
		@(posedge clock);
		checkValue("first fetch strobe", word_t'(1), word_t'(memRead));
		waitForHalt();
		repeat (QUIET_CYCLES)
			@(posedge clock); // the core must stay quiet while halted
		checkValue("store count", word_t'(programStores), word_t'(storeCount));
		checkValue("pending stores", '0, word_t'(storeAddrQ.size()));
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+source
source/cpuPkg.sv
source/aluUnit.sv
source/controlSequencer.sv
source/busDatapath.sv
source/memoryInterface.sv
source/programUnit.sv
source/cpuCore.sv
bench/cpuCore_properties.sv
bench/cpuCoreTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the cpuCore testbench with Verilator.
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f all.f --top-module cpuCoreTb -Mdir obj_dir -o cpuCoreSim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/cpuCoreSim > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "Checks failed" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi
exit 0
